//--- filelist.f
+incdir+logic
logic/sram_pkg.sv
logic/sram_controller.sv
logic/mem_port_arbiter.sv
logic/byte_lane_align.sv
logic/sram_subsystem_top.sv
verification/tb_clock_gen.sv
verification/sram_model.sv
verification/sram_checker.sv
verification/sram_tb.sv

//--- logic/byte_lane_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_params.svh"

module byte_lane_align (
    input  sram_pkg::data_req_t req,
    output sram_pkg::word_req_t word_req,
    input  sram_pkg::word_t     word_rdata,
    output sram_pkg::word_t     rdata
);
    import sram_pkg::*;

    logic [1:0] lane;
    word_t      shifted;

    assign lane    = req.addr[1:0];
    assign shifted = word_rdata >> {lane, 3'b000};   // selected lane down to bit 0

    always_comb begin
        word_req.rd   = req.rd;
        word_req.wr   = req.wr;
        word_req.addr = req.addr[`BUS_ADDR_W-1:2];
        case (req.size)
            SIZE_BYTE: begin
                word_req.mask  = mask_t'(1) << lane;
                word_req.wdata = {4{req.wdata[7:0]}};
            end
            SIZE_HALF: begin
                word_req.mask  = lane[1] ? 4'b1100 : 4'b0011;
                word_req.wdata = {2{req.wdata[15:0]}};
            end
            default: begin
                word_req.mask  = '1;
                word_req.wdata = req.wdata;
            end
        endcase
    end

    // load extension
    always_comb begin
        case (req.size)
            SIZE_BYTE: rdata = {{24{req.signed_ld & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: rdata = {{16{req.signed_ld & shifted[15]}}, shifted[15:0]};
            default:   rdata = word_rdata;
        endcase
    end

    // requester contract, no trap logic behind it
    always_comb begin
        assert final (!(req.rd && req.wr))
            else $error("data port read and write both high at %0t", $time);
        if ((req.rd || req.wr) && req.size == SIZE_HALF) begin
            assert final (!req.addr[0])
                else $error("misaligned half access at %0t", $time);
        end
        if ((req.rd || req.wr) && req.size == SIZE_WORD) begin
            assert final (req.addr[1:0] == 2'b00)
                else $error("misaligned word access at %0t", $time);
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter (
    input  logic                clk,
    input  logic                rst,

    input  logic                fetch_req,
    input  sram_pkg::ram_addr_t fetch_addr,
    output logic                fetch_done,
    output sram_pkg::word_t     fetch_rdata,

    input  sram_pkg::word_req_t data_word_req,
    output logic                data_done,
    output sram_pkg::word_t     data_rdata,

    output logic                start,
    output sram_pkg::word_req_t ctrl_req,
    input  logic                ctrl_done,
    input  sram_pkg::word_t     ctrl_rdata
);
    import sram_pkg::*;

    logic      busy;
    logic      owner_data;    // 1 while the data port holds the grant
    logic      data_pending;
    logic      sel_data;
    word_req_t fetch_word_req;

    assign data_pending = data_word_req.rd | data_word_req.wr;

    // fetch is always a full word read
    always_comb begin
        fetch_word_req       = '0;
        fetch_word_req.rd    = fetch_req;
        fetch_word_req.addr  = fetch_addr;
        fetch_word_req.mask  = '1;
    end

    assign start    = !busy && (data_pending || fetch_req);
    assign sel_data = busy ? owner_data : data_pending;   // data wins on a tie
    assign ctrl_req = sel_data ? data_word_req : fetch_word_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            owner_data <= 1'b0;
        end else if (start) begin
            busy       <= 1'b1;
            owner_data <= data_pending;
        end else if (ctrl_done) begin
            busy <= 1'b0;
        end
    end

    assign fetch_done  = ctrl_done & ~owner_data;
    assign data_done   = ctrl_done & owner_data;
    assign fetch_rdata = ctrl_rdata;    // qualified by each port's done
    assign data_rdata  = ctrl_rdata;

    assert property (@(posedge clk) disable iff (rst) start |-> !(ctrl_req.rd && ctrl_req.wr))
        else $error("read and write both set on granted request at %0t", $time);

    // done is only routed back to a port that is still waiting
    assert property (@(posedge clk) disable iff (rst) fetch_done |-> fetch_req)
        else $error("fetch_done with no fetch request at %0t", $time);

    assert property (@(posedge clk) disable iff (rst) data_done |-> data_pending)
        else $error("data_done with no data request at %0t", $time);

endmodule

`default_nettype wire

//--- logic/sram_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_params.svh"

module sram_controller (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  sram_pkg::word_req_t  req,
    output logic                 done,
    output sram_pkg::word_t      rdata,
    output sram_pkg::sram_pins_t pins,
    inout  wire sram_pkg::word_t ram_data
);
    import sram_pkg::*;

    typedef enum logic [1:0] {IDLE, READ, WRITE} state_t;

    state_t state;
    logic   drive;      // we own the data bus
    word_t  wdata_q;

    assign ram_data = drive ? wdata_q : 'z;

    // chip strobes and sequencing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            pins.addr <= `SRAM_IDLE_WORD;
            pins.be_n <= '1;
            pins.ce_n <= 1'b1;
            pins.oe_n <= 1'b1;
            pins.we_n <= 1'b1;
            drive     <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        pins.addr <= req.addr;
                        pins.be_n <= ~req.mask;
                        pins.ce_n <= 1'b0;
                        pins.oe_n <= ~req.rd;
                        pins.we_n <= ~req.wr;
                        drive     <= req.wr;
                        state     <= req.rd ? READ : WRITE;
                    end else begin
                        // park the pins
                        pins.addr <= `SRAM_IDLE_WORD;
                        pins.be_n <= '1;
                        pins.ce_n <= 1'b1;
                        pins.oe_n <= 1'b1;
                        pins.we_n <= 1'b1;
                    end
                end
                READ: begin
                    pins.ce_n <= 1'b1;
                    pins.oe_n <= 1'b1;
                    pins.we_n <= 1'b1;
                    done      <= 1'b1;
                    state     <= IDLE;
                end
                WRITE: begin
                    pins.ce_n <= 1'b1;
                    pins.oe_n <= 1'b1;
                    pins.we_n <= 1'b1;
                    drive     <= 1'b0;   // release bus with we_n
                    done      <= 1'b1;
                    state     <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // write data latched on accept, read data sampled one edge later
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            wdata_q <= req.wdata;
        end
        if (state == READ) begin
            rdata <= ram_data;
        end
    end

    // chip must never see output and write enable together
    assert property (@(posedge clk) disable iff (rst) !(!pins.oe_n && !pins.we_n))
        else $error("oe_n and we_n both low at %0t", $time);

    // the arbiter may only start us while idle
    assert property (@(posedge clk) disable iff (rst) start |-> state == IDLE)
        else $error("start outside IDLE at %0t", $time);

    assert property (@(posedge clk) disable iff (rst) start |-> ##2 done)
        else $error("done missing two cycles after start at %0t", $time);

    assert property (@(posedge clk) disable iff (rst) done |-> $past(start, 2))
        else $error("done without start two cycles earlier at %0t", $time);

endmodule

`default_nettype wire

//--- logic/sram_params.svh
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// data bus width in bits
`define SRAM_DATA_W 32

// word address into the chip, 1M words
`define SRAM_ADDR_W 20

// byte address as seen by the cpu
`define BUS_ADDR_W 22

// parked on the address pins between accesses
`define SRAM_IDLE_WORD ('1)

`endif

//--- logic/sram_pkg.sv
`default_nettype none

`include "sram_params.svh"

package sram_pkg;

    typedef logic [`SRAM_DATA_W-1:0]   word_t;
    typedef logic [`SRAM_ADDR_W-1:0]   ram_addr_t;
    typedef logic [`BUS_ADDR_W-1:0]    bus_addr_t;
    typedef logic [`SRAM_DATA_W/8-1:0] mask_t;     // one bit per byte lane

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} acc_size_t;

    // lane-resolved request, what the chip side understands
    typedef struct packed {
        logic      rd;
        logic      wr;
        ram_addr_t addr;
        mask_t     mask;
        word_t     wdata;
    } word_req_t;

    // sized request from the data port, byte addressed
    typedef struct packed {
        logic      rd;
        logic      wr;
        bus_addr_t addr;
        acc_size_t size;
        logic      signed_ld;  // sign extend on byte/half loads
        word_t     wdata;      // right aligned
    } data_req_t;

    typedef struct packed {
        ram_addr_t addr;
        mask_t     be_n;
        logic      ce_n;
        logic      oe_n;
        logic      we_n;
    } sram_pins_t;

endpackage

`default_nettype wire

//--- logic/sram_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_subsystem_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_req,
    input  sram_pkg::ram_addr_t  fetch_addr,
    output logic                 fetch_done,
    output sram_pkg::word_t      fetch_rdata,
    input  sram_pkg::data_req_t  data_req,
    output logic                 data_done,
    output sram_pkg::word_t      data_rdata,
    output sram_pkg::sram_pins_t pins,
    inout  wire sram_pkg::word_t ram_data
);
    import sram_pkg::*;

    word_req_t data_word_req;
    word_req_t ctrl_req;
    word_t     data_word_rdata;
    word_t     ctrl_rdata;
    logic      start;
    logic      ctrl_done;

    byte_lane_align u_align (
        .req        (data_req),
        .word_req   (data_word_req),
        .word_rdata (data_word_rdata),
        .rdata      (data_rdata)
    );

    mem_port_arbiter u_arb (
        .clk           (clk),
        .rst           (rst),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_done    (fetch_done),
        .fetch_rdata   (fetch_rdata),
        .data_word_req (data_word_req),
        .data_done     (data_done),
        .data_rdata    (data_word_rdata),
        .start         (start),
        .ctrl_req      (ctrl_req),
        .ctrl_done     (ctrl_done),
        .ctrl_rdata    (ctrl_rdata)
    );

    sram_controller u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .req      (ctrl_req),
        .done     (ctrl_done),
        .rdata    (ctrl_rdata),
        .pins     (pins),
        .ram_data (ram_data)
    );

endmodule

`default_nettype wire

//--- verification/sram_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sram_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_req,
    input  sram_pkg::ram_addr_t  fetch_addr,
    input  logic                 fetch_done,
    input  sram_pkg::word_t      fetch_rdata,
    input  sram_pkg::data_req_t  data_req,
    input  logic                 data_done,
    input  sram_pkg::word_t      data_rdata,
    input  sram_pkg::sram_pins_t pins,
    output int                   errors
);
    import sram_pkg::*;

    logic [7:0] shadow [int];   // byte image, keyed by byte address
    sram_pins_t act_pins;       // pins of the access in flight
    logic       seen_req;
    int         n;

    initial begin
        errors   = 0;
        seen_req = 1'b0;
    end

    // little endian gather from the shadow, then extend
    function automatic word_t expected_read(int addr, int nbytes, logic sgn);
        word_t v;
        v = '0;
        for (int i = nbytes - 1; i >= 0; i--) begin
            v = (v << 8) | (shadow.exists(addr + i) ? shadow[addr + i] : 8'hxx);
        end
        if (sgn && nbytes < 4 && v[8*nbytes-1]) begin
            v = v | (~word_t'(0) << (8 * nbytes));
        end
        return v;
    endfunction

    function automatic mask_t expected_be_n(int addr, int nbytes);
        mask_t be_n;
        be_n = '1;
        for (int i = 0; i < nbytes; i++) begin
            be_n[(addr + i) % 4] = 1'b0;   // touched lanes go low
        end
        return be_n;
    endfunction

    task automatic compare(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (!seen_req && !(pins.ce_n && pins.oe_n && pins.we_n && &pins.addr)) begin
                $display("chip pins not parked while no request was made, at %0t", $time);
                errors++;
            end
            seen_req |= fetch_req | data_req.rd | data_req.wr;
            if (!pins.ce_n) begin
                act_pins = pins;
            end
            if (fetch_done && !fetch_req) begin
                $display("fetch_done arrived with no fetch request at %0t", $time);
                errors++;
            end else if (fetch_done) begin
                compare("pins.addr", fetch_addr, act_pins.addr);
                compare("pins.be_n", '0, act_pins.be_n);
                compare("pins.oe_n", 1'b0, act_pins.oe_n);
                compare("pins.we_n", 1'b1, act_pins.we_n);
                compare("fetch_rdata", expected_read({fetch_addr, 2'b00}, 4, 1'b0), fetch_rdata);
            end
            if (data_done && !(data_req.rd || data_req.wr)) begin
                $display("data_done arrived with no data request at %0t", $time);
                errors++;
            end else if (data_done) begin
                n = (data_req.size == SIZE_BYTE) ? 1 : (data_req.size == SIZE_HALF) ? 2 : 4;
                compare("pins.addr", data_req.addr >> 2, act_pins.addr);
                compare("pins.be_n", expected_be_n(data_req.addr, n), act_pins.be_n);
                if (data_req.wr) begin
                    compare("pins.oe_n", 1'b1, act_pins.oe_n);
                    compare("pins.we_n", 1'b0, act_pins.we_n);
                    for (int i = 0; i < n; i++) begin
                        shadow[data_req.addr + i] = data_req.wdata[8*i +: 8];
                    end
                end else begin
                    compare("pins.oe_n", 1'b0, act_pins.oe_n);
                    compare("pins.we_n", 1'b1, act_pins.we_n);
                    compare("data_rdata", expected_read(data_req.addr, n, data_req.signed_ld),
                            data_rdata);
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- verification/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model (
    input  sram_pkg::sram_pins_t pins,
    inout  wire sram_pkg::word_t ram_data
);
    import sram_pkg::*;

    word_t mem [0:2**$bits(ram_addr_t)-1];

    // chip drives the bus while selected with output enable low
    assign ram_data = (!pins.ce_n && !pins.oe_n) ? mem[pins.addr] : 'z;

    // write lands inside the we_n pulse once the bus has settled
    always @(negedge pins.we_n) begin
        #1;
        if (!pins.ce_n && !pins.we_n) begin
            for (int i = 0; i < 4; i++) begin
                if (!pins.be_n[i]) begin
                    mem[pins.addr][8*i +: 8] = ram_data[8*i +: 8];
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- verification/sram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sram_tb;
    import sram_pkg::*;

    localparam int        N_RANDOM = 400;
    localparam int        N_REQ    = N_RANDOM + 70;
    localparam bus_addr_t BASE     = 22'h15_a400;   // 32 word window

    logic       clk;
    logic       rst;
    logic       fetch_req;
    logic       fetch_done;
    logic       data_done;
    ram_addr_t  fetch_addr;
    word_t      fetch_rdata;
    word_t      data_rdata;
    data_req_t  data_req;
    sram_pins_t pins;
    wire word_t ram_data;
    integer     seed;
    int         stim_errors;
    int         chk_errors;
    int         cyc_data;
    int         cyc_fetch;

    tb_clock_gen       clk_gen (.clk(clk), .rst(rst));
    sram_subsystem_top dut (.*);
    sram_model         ram (.pins(pins), .ram_data(ram_data));
    sram_checker       chk (.*, .errors(chk_errors));

    // holds the request until done and counts cycles from the drive
    task automatic data_access(input logic wr, input bus_addr_t addr, input acc_size_t size,
                               input logic sgn, input word_t wdata, output int cycles);
        data_req = '{rd: !wr, wr: wr, addr: addr, size: size, signed_ld: sgn, wdata: wdata};
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!data_done && cycles < 64);
        if (!data_done) begin
            $display("data_done never arrived for address %h", addr);
            stim_errors++;
        end
        @(negedge clk);   // held through the done edge
        data_req = '0;
    endtask

    task automatic fetch_access(input ram_addr_t addr, output int cycles);
        fetch_req  = 1'b1;
        fetch_addr = addr;
        cycles     = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!fetch_done && cycles < 64);
        if (!fetch_done) begin
            $display("fetch_done never arrived for address %h", addr);
            stim_errors++;
        end
        @(negedge clk);
        fetch_req = 1'b0;
    endtask

    task automatic check_latency(string name, int got, int exp);
        if (got != exp) begin
            $display("Error at %0t: %s latency expected %0d, got %0d", $time, name, exp, got);
            stim_errors++;
        end
    endtask

    task automatic random_data(input int count);
        bus_addr_t addr;
        acc_size_t size;
        logic      wr;
        logic      sgn;
        int        cycles;
        repeat (count) begin
            size = acc_size_t'($unsigned($random(seed)) % 3);
            addr = BASE + $unsigned($random(seed)) % 128;
            addr = addr & ~bus_addr_t'(size == SIZE_WORD ? 3 : size == SIZE_HALF ? 1 : 0);
            wr   = ($random(seed) & 1) != 0;
            sgn  = ($random(seed) & 1) != 0;
            data_access(wr, addr, size, sgn, $random(seed), cycles);
            repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        end
    endtask

    task automatic random_fetch(input int count);
        int cycles;
        repeat (count) begin
            fetch_access(BASE[21:2] + $unsigned($random(seed)) % 32, cycles);
            repeat ($unsigned($random(seed)) % 4) @(negedge clk);
        end
    endtask

    initial begin
        seed        = 32'hb5b1_6734;
        stim_errors = 0;
        fetch_req   = 1'b0;
        fetch_addr  = '0;
        data_req    = '0;
        wait (rst == 1'b0);
        repeat (5) @(negedge clk);   // quiet bus after reset
        for (int i = 0; i < 32; i++) begin
            data_access(1'b1, BASE + 4 * i, SIZE_WORD, 1'b0,
                        word_t'(BASE + 4 * i) * 32'h9e37_79b1, cyc_data);
        end
        data_access(1'b1, BASE + 'h10, SIZE_WORD, 1'b0, 32'hcafe_f00d, cyc_data);
        check_latency("data_done", cyc_data, 2);
        data_access(1'b0, BASE + 'h10, SIZE_WORD, 1'b0, '0, cyc_data);
        check_latency("data_done", cyc_data, 2);
        // bytes into one word, a half into the upper half of the next
        for (int i = 0; i < 4; i++) begin
            data_access(1'b1, BASE + 'h20 + i, SIZE_BYTE, 1'b0, 32'h70 + 16 * i, cyc_data);
        end
        data_access(1'b1, BASE + 'h26, SIZE_HALF, 1'b0, 32'hffff_9abc, cyc_data);
        for (int i = 0; i < 8; i++) begin
            data_access(1'b0, BASE + 'h20 + i % 4, SIZE_BYTE, i / 4, '0, cyc_data);
        end
        for (int i = 0; i < 4; i++) begin
            data_access(1'b0, BASE + 'h24 + 2 * (i % 2), SIZE_HALF, i / 2, '0, cyc_data);
        end
        data_access(1'b0, BASE + 'h24, SIZE_WORD, 1'b0, '0, cyc_data);
        for (int i = 0; i < 12; i++) begin
            fetch_access(BASE[21:2] + i, cyc_fetch);
            check_latency("fetch_done", cyc_fetch, 2);
        end
        fork   // raised on the same edge so the data port wins
            data_access(1'b0, BASE + 'h20, SIZE_WORD, 1'b0, '0, cyc_data);
            fetch_access(BASE[21:2] + 9, cyc_fetch);
        join
        check_latency("data_done", cyc_data, 2);
        if (cyc_fetch <= cyc_data) begin
            $display("fetch_done did not come after data_done on a tied request");
            stim_errors++;
        end
        fork
            random_data(N_RANDOM / 2);
            random_fetch(N_RANDOM / 2);
        join
        repeat (4) @(negedge clk);
        $display("checker errors: %0d, stimulus errors: %0d", chk_errors, stim_errors);
        if (chk_errors + stim_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // bound of 20 cycles per request plus margin
    initial begin
        #(N_REQ * 20 * 4 + 2000);
        $display("timeout, requests still outstanding at %0t", $time);
        $display("Test failures found");
        $finish;
    end
endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end
endmodule

`default_nettype wire
